/* axi_read_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module axi_read_arbiter
    import bridge_pkg::*;
(
    input  wire logic    aclk_i,
    input  wire logic    arst_n_i,

    // icache read port
    input  wire logic    ic_pending_i,
    input  wire axi_ar_t ic_ar_i,
    output logic         ic_grant_o,
    output logic         ic_r_valid_o,

    // dcache read port
    input  wire logic    dc_pending_i,
    input  wire axi_ar_t dc_ar_i,
    output logic         dc_grant_o,
    output logic         dc_r_valid_o,

    // beat shared by both ports
    output rd_beat_t     r_beat_o,

    // AXI AR and R
    output axi_ar_t      ar_o,
    output logic         arvalid_o,
    input  wire logic    arready_i,
    input  wire axi_r_t  r_i,
    input  wire logic    rvalid_i,
    output logic         rready_o
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       owner_dc_q;  // burst belongs to the dcache port
    logic       prio_dc_q;   // dcache wins a tie
    logic       pick_dc;
    logic       any_pending;
    logic       r_fire;

    assign any_pending = ic_pending_i | dc_pending_i;
    assign pick_dc     = dc_pending_i & (~ic_pending_i | prio_dc_q);
    assign r_fire      = rready_o & rvalid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (any_pending)
                    state_d = ARB_ADDR;
            end
            ARB_ADDR: begin
                if (arready_i)
                    state_d = ARB_DATA;
            end
            ARB_DATA: begin
                if (r_fire && r_i.last)
                    state_d = ARB_IDLE;
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ARB_IDLE;
            owner_dc_q <= 1'b0;
            prio_dc_q  <= 1'b0;  // icache first after reset
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE && any_pending)
                owner_dc_q <= pick_dc;  // grant registered here
            if (r_fire && r_i.last)
                prio_dc_q <= ~owner_dc_q;  // other port next time
        end
    end

    // owner's AR payload is stable while it is pending
    assign ar_o      = owner_dc_q ? dc_ar_i : ic_ar_i;
    assign arvalid_o = (state_q == ARB_ADDR);

    assign ic_grant_o = arvalid_o & arready_i & ~owner_dc_q;
    assign dc_grant_o = arvalid_o & arready_i & owner_dc_q;

    // R beats routed to the burst owner in the same cycle
    assign rready_o      = (state_q == ARB_DATA);
    assign ic_r_valid_o  = r_fire & ~owner_dc_q;
    assign dc_r_valid_o  = r_fire & owner_dc_q;
    assign r_beat_o.data = r_i.data;
    assign r_beat_o.last = r_i.last;

endmodule

`default_nettype wire

/* bridge_params.svh */
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// bus widths
`define BRG_ADDR_W      32
`define BRG_DATA_W      32
`define BRG_ID_W        4
`define BRG_LEN_W       8
`define BRG_STRB_W      4

// client beat count, 1 to 256 beats per burst
`define BRG_BEAT_CNT_W  9

// fixed AXI IDs per cache port
`define BRG_ICACHE_ID   4'd1
`define BRG_DCACHE_ID   4'd0

// fabric assumes word beats and INCR bursts
`define BRG_SIZE_WORD   3'b010
`define BRG_BURST_INCR  2'b01

`endif

/* bridge_pkg.sv */
`default_nettype none

`include "bridge_params.svh"

package bridge_pkg;

    typedef struct packed {
        logic [`BRG_ADDR_W-1:0]     addr;
        logic [`BRG_BEAT_CNT_W-1:0] cnt;   // beats, 1..256
    } rd_req_t;

    typedef struct packed {
        logic [`BRG_ADDR_W-1:0]     addr;
        logic [`BRG_BEAT_CNT_W-1:0] cnt;
    } wr_req_t;

    typedef struct packed {
        logic [`BRG_DATA_W-1:0] data;
        logic [`BRG_STRB_W-1:0] strb;
    } wr_beat_t;

    typedef struct packed {
        logic [`BRG_DATA_W-1:0] data;
        logic                   last;
    } rd_beat_t;

    typedef struct packed {
        logic [`BRG_ID_W-1:0]   id;
        logic [`BRG_ADDR_W-1:0] addr;
        logic [`BRG_LEN_W-1:0]  len;   // beats minus one
    } axi_ar_t;

    typedef struct packed {
        logic [`BRG_ID_W-1:0]   id;
        logic [`BRG_ADDR_W-1:0] addr;
        logic [`BRG_LEN_W-1:0]  len;
    } axi_aw_t;

    typedef struct packed {
        logic [`BRG_DATA_W-1:0] data;
        logic [`BRG_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`BRG_ID_W-1:0]   id;
        logic [`BRG_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA
    } arb_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

endpackage

`default_nettype wire

/* bridge_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module bridge_props
    import bridge_pkg::*;
(
    input wire logic    aclk_i,
    input wire logic    arst_n_i,
    input wire logic    arvalid_o,
    input wire logic    arready_i,
    input wire axi_ar_t ar_o,
    input wire logic    rready_o,
    input wire logic    rvalid_i,
    input wire axi_r_t  r_i,
    input wire logic    awvalid_o,
    input wire logic    awready_i,
    input wire axi_aw_t aw_o,
    input wire logic    wvalid_o,
    input wire logic    wready_i,
    input wire axi_w_t  w_o
);

    logic [`BRG_LEN_W-1:0] aw_len_q;  // len of the burst on W
    logic [`BRG_LEN_W-1:0] w_cnt_q;   // W beats taken so far
    logic                  ar_open_q; // AR accepted, rlast not yet seen

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aw_len_q <= '0;
            w_cnt_q  <= '0;
        end else if (awvalid_o && awready_i) begin
            aw_len_q <= aw_o.len;
            w_cnt_q  <= '0;
        end else if (wvalid_o && wready_i) begin
            w_cnt_q <= w_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            ar_open_q <= 1'b0;
        else if (arvalid_o && arready_i)
            ar_open_q <= 1'b1;
        else if (rvalid_i && rready_o && r_i.last)
            ar_open_q <= 1'b0;
    end

    ar_hold: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
        else $error("AR valid dropped or payload changed before arready");

    aw_hold: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
        else $error("AW valid dropped or payload changed before awready");

    w_hold: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
        else $error("W valid dropped or payload changed before wready");

    // data phase only after the address is taken, up to rlast
    r_after_ar: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        rready_o |-> ar_open_q && !arvalid_o)
        else $error("rready high without an accepted AR or while AR still pending");

    wlast_pos: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        wvalid_o |-> (w_o.last == (w_cnt_q == aw_len_q)))
        else $error("wlast not on the last counted W beat");

endmodule

`default_nettype wire

/* cache_read_port.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module cache_read_port
    import bridge_pkg::*;
#(
    parameter logic [`BRG_ID_W-1:0] PORT_ID = '0
) (
    input  wire logic     aclk_i,
    input  wire logic     arst_n_i,

    // cache side
    input  wire logic     req_valid_i,
    output logic          req_ready_o,
    input  wire rd_req_t  req_i,
    output logic          resp_valid_o,
    output rd_beat_t      resp_o,

    // arbiter side
    output logic          ar_pending_o,
    output axi_ar_t       ar_o,
    input  wire logic     ar_grant_i,
    input  wire logic     r_valid_i,
    input  wire rd_beat_t r_beat_i
);

    logic                       busy_q;     // burst in flight
    logic                       pending_q;  // AR not yet taken by the bus
    logic [`BRG_ADDR_W-1:0]     addr_q;
    logic [`BRG_LEN_W-1:0]      len_q;
    logic [`BRG_BEAT_CNT_W-1:0] len_full;
    logic                       req_fire;

    assign req_ready_o = ~busy_q;
    assign req_fire    = req_valid_i & req_ready_o;
    assign len_full    = req_i.cnt - 1'b1;  // AXI len counts from zero

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (req_fire) begin
                busy_q    <= 1'b1;
                pending_q <= 1'b1;
            end else begin
                if (ar_grant_i)
                    pending_q <= 1'b0;
                if (r_valid_i && r_beat_i.last)
                    busy_q <= 1'b0;  // ready again next cycle
            end
        end
    end

    // request payload, held for the whole burst
    always_ff @(posedge aclk_i) begin
        if (req_fire) begin
            addr_q <= req_i.addr;
            len_q  <= len_full[`BRG_LEN_W-1:0];
        end
    end

    assign ar_pending_o = pending_q;
    assign ar_o.id      = PORT_ID;
    assign ar_o.addr    = addr_q;
    assign ar_o.len     = len_q;

    // beats go straight to the cache, no back-pressure
    assign resp_valid_o = r_valid_i & busy_q;
    assign resp_o       = r_beat_i;

endmodule

`default_nettype wire

/* cpu_axi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module cpu_axi_bridge
    import bridge_pkg::*;
(
    input  wire logic       aclk_i,
    input  wire logic       arst_n_i,

    // icache refill
    input  wire logic       ic_req_valid_i,
    output logic            ic_req_ready_o,
    input  wire rd_req_t    ic_req_i,
    output logic            ic_resp_valid_o,
    output rd_beat_t        ic_resp_o,

    // dcache refill
    input  wire logic       dc_req_valid_i,
    output logic            dc_req_ready_o,
    input  wire rd_req_t    dc_req_i,
    output logic            dc_resp_valid_o,
    output rd_beat_t        dc_resp_o,

    // dcache write
    input  wire logic       wr_req_valid_i,
    output logic            wr_req_ready_o,
    input  wire wr_req_t    wr_req_i,
    input  wire logic       wdata_valid_i,
    output logic            wdata_ready_o,
    input  wire wr_beat_t   wdata_i,
    output logic            wr_done_o,
    output logic [1:0]      wr_resp_o,

    // AXI master
    output axi_ar_t         ar_o,
    output logic            arvalid_o,
    input  wire logic       arready_i,
    input  wire axi_r_t     r_i,
    input  wire logic       rvalid_i,
    output logic            rready_o,
    output axi_aw_t         aw_o,
    output logic            awvalid_o,
    input  wire logic       awready_i,
    output axi_w_t          w_o,
    output logic            wvalid_o,
    input  wire logic       wready_i,
    input  wire logic       bvalid_i,
    input  wire logic [1:0] bresp_i,
    output logic            bready_o
);

    logic     ic_pending;
    logic     ic_grant;
    logic     ic_r_valid;
    axi_ar_t  ic_ar;
    logic     dc_pending;
    logic     dc_grant;
    logic     dc_r_valid;
    axi_ar_t  dc_ar;
    rd_beat_t r_beat;

    cache_read_port #(.PORT_ID(`BRG_ICACHE_ID)) u_icache_rd (
        .aclk_i       (aclk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (ic_req_valid_i),
        .req_ready_o  (ic_req_ready_o),
        .req_i        (ic_req_i),
        .resp_valid_o (ic_resp_valid_o),
        .resp_o       (ic_resp_o),
        .ar_pending_o (ic_pending),
        .ar_o         (ic_ar),
        .ar_grant_i   (ic_grant),
        .r_valid_i    (ic_r_valid),
        .r_beat_i     (r_beat)
    );

    cache_read_port #(.PORT_ID(`BRG_DCACHE_ID)) u_dcache_rd (
        .aclk_i       (aclk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (dc_req_valid_i),
        .req_ready_o  (dc_req_ready_o),
        .req_i        (dc_req_i),
        .resp_valid_o (dc_resp_valid_o),
        .resp_o       (dc_resp_o),
        .ar_pending_o (dc_pending),
        .ar_o         (dc_ar),
        .ar_grant_i   (dc_grant),
        .r_valid_i    (dc_r_valid),
        .r_beat_i     (r_beat)
    );

    axi_read_arbiter u_rd_arb (
        .aclk_i       (aclk_i),
        .arst_n_i     (arst_n_i),
        .ic_pending_i (ic_pending),
        .ic_ar_i      (ic_ar),
        .ic_grant_o   (ic_grant),
        .ic_r_valid_o (ic_r_valid),
        .dc_pending_i (dc_pending),
        .dc_ar_i      (dc_ar),
        .dc_grant_o   (dc_grant),
        .dc_r_valid_o (dc_r_valid),
        .r_beat_o     (r_beat),
        .ar_o         (ar_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o)
    );

    // only the dcache side writes
    dcache_write_port u_dcache_wr (
        .aclk_i         (aclk_i),
        .arst_n_i       (arst_n_i),
        .wr_req_valid_i (wr_req_valid_i),
        .wr_req_ready_o (wr_req_ready_o),
        .wr_req_i       (wr_req_i),
        .wdata_valid_i  (wdata_valid_i),
        .wdata_ready_o  (wdata_ready_o),
        .wdata_i        (wdata_i),
        .wr_done_o      (wr_done_o),
        .wr_resp_o      (wr_resp_o),
        .aw_o           (aw_o),
        .awvalid_o      (awvalid_o),
        .awready_i      (awready_i),
        .w_o            (w_o),
        .wvalid_o       (wvalid_o),
        .wready_i       (wready_i),
        .bvalid_i       (bvalid_i),
        .bresp_i        (bresp_i),
        .bready_o       (bready_o)
    );

endmodule

`default_nettype wire

/* dcache_write_port.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module dcache_write_port
    import bridge_pkg::*;
(
    input  wire logic     aclk_i,
    input  wire logic     arst_n_i,

    // data cache side
    input  wire logic     wr_req_valid_i,
    output logic          wr_req_ready_o,
    input  wire wr_req_t  wr_req_i,
    input  wire logic     wdata_valid_i,
    output logic          wdata_ready_o,
    input  wire wr_beat_t wdata_i,
    output logic          wr_done_o,
    output logic [1:0]    wr_resp_o,

    // AXI write channels
    output axi_aw_t       aw_o,
    output logic          awvalid_o,
    input  wire logic     awready_i,
    output axi_w_t        w_o,
    output logic          wvalid_o,
    input  wire logic     wready_i,
    input  wire logic     bvalid_i,
    input  wire logic [1:0] bresp_i,
    output logic          bready_o
);

    wr_state_e                  state_q;
    wr_state_e                  state_d;
    logic [`BRG_ADDR_W-1:0]     addr_q;
    logic [`BRG_LEN_W-1:0]      len_q;
    logic [`BRG_BEAT_CNT_W-1:0] total_q;  // beats requested
    logic [`BRG_BEAT_CNT_W-1:0] beat_q;   // index of current W beat, from 1
    logic [`BRG_BEAT_CNT_W-1:0] len_full;
    logic                       req_fire;
    logic                       w_fire;
    logic                       w_last;

    assign req_fire = wr_req_valid_i & wr_req_ready_o;
    assign w_fire   = wvalid_o & wready_i;
    assign w_last   = (beat_q == total_q);
    assign len_full = wr_req_i.cnt - 1'b1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (req_fire)
                    state_d = WR_ADDR;
            end
            WR_ADDR: begin
                if (awready_i)
                    state_d = WR_DATA;
            end
            WR_DATA: begin
                if (w_fire && w_last)
                    state_d = WR_RESP;
            end
            WR_RESP: begin
                if (bvalid_i)
                    state_d = WR_IDLE;
            end
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WR_IDLE;
            total_q <= '0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (req_fire) begin
                total_q <= wr_req_i.cnt;
                beat_q  <= 1;
            end else if (w_fire) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (req_fire) begin
            addr_q <= wr_req_i.addr;
            len_q  <= len_full[`BRG_LEN_W-1:0];
        end
    end

    assign wr_req_ready_o = (state_q == WR_IDLE);

    // AW held until awready
    assign awvalid_o = (state_q == WR_ADDR);
    assign aw_o.id   = `BRG_DCACHE_ID;
    assign aw_o.addr = addr_q;
    assign aw_o.len  = len_q;

    // W passes the client beats through once AW is done
    assign wvalid_o      = (state_q == WR_DATA) & wdata_valid_i;
    assign wdata_ready_o = (state_q == WR_DATA) & wready_i;
    assign w_o.data      = wdata_i.data;
    assign w_o.strb      = wdata_i.strb;
    assign w_o.last      = w_last;

    assign bready_o  = (state_q == WR_RESP);
    assign wr_done_o = bready_o & bvalid_i;  // one cycle, with B
    assign wr_resp_o = bresp_i;

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
bridge_pkg.sv
cache_read_port.sv
dcache_write_port.sv
axi_read_arbiter.sv
cpu_axi_bridge.sv
bridge_props.sv
tb_cpu_axi_bridge.sv

/* tb_cpu_axi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_params.svh"

module tb_cpu_axi_bridge
    import bridge_pkg::*;
();

    localparam int TEST_BEATS  = 8 + 4 + 24 + 4 + 4 + 6 + 8 * 32;  // upper bound over all tests
    localparam int WORST_DELAY = 16;                              // cycles per beat, stalls included
    localparam int CYCLE_LIMIT = TEST_BEATS * WORST_DELAY + 500;

    logic aclk;
    logic arst_n;
    logic ic_req_valid;
    rd_req_t ic_req;
    logic dc_req_valid;
    rd_req_t dc_req;
    logic wr_req_valid;
    wr_req_t wr_req;
    logic wdata_valid;
    wr_beat_t wdata;
    logic ic_req_ready;
    logic ic_resp_valid;
    rd_beat_t ic_resp;
    logic dc_req_ready;
    logic dc_resp_valid;
    rd_beat_t dc_resp;
    logic wr_req_ready;
    logic wdata_ready;
    logic wr_done;
    logic [1:0] wr_resp;
    axi_ar_t ar_ch;
    logic arvalid;
    logic rready;
    axi_aw_t aw_ch;
    logic awvalid;
    axi_w_t w_ch;
    logic wvalid;
    logic bready;

    // slave model state
    logic arready = 1'b0;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic rvalid = 1'b0;
    axi_r_t r_ch = '0;
    logic bvalid = 1'b0;
    logic [1:0] bresp = 2'b00;
    logic [31:0] mem_q [0:1023];
    logic [31:0] rd_addr;
    logic [8:0] rd_left;
    logic [3:0] rd_id;
    logic [31:0] wr_addr;
    logic b_pend;
    logic [31:0] addr_v;
    logic [8:0] left_v;

    // reference state
    logic [31:0] exp_mem [0:1023];
    logic exp_wr [0:1023];
    logic [32:0] exp_q [2][$];   // {data, last}, indexed by AXI ID
    logic [39:0] ar_exp [2][$];  // {addr, len}
    logic [3:0] ar_ids [$];
    logic [31:0] exp_aw_addr;
    logic [7:0] exp_aw_len;
    int w_seen;
    int done_cnt;
    int err_cnt;
    int fail_cnt;
    int cycles;
    int order_start;

    cpu_axi_bridge dut0 (
        .aclk_i          (aclk),
        .arst_n_i        (arst_n),
        .ic_req_valid_i  (ic_req_valid),
        .ic_req_ready_o  (ic_req_ready),
        .ic_req_i        (ic_req),
        .ic_resp_valid_o (ic_resp_valid),
        .ic_resp_o       (ic_resp),
        .dc_req_valid_i  (dc_req_valid),
        .dc_req_ready_o  (dc_req_ready),
        .dc_req_i        (dc_req),
        .dc_resp_valid_o (dc_resp_valid),
        .dc_resp_o       (dc_resp),
        .wr_req_valid_i  (wr_req_valid),
        .wr_req_ready_o  (wr_req_ready),
        .wr_req_i        (wr_req),
        .wdata_valid_i   (wdata_valid),
        .wdata_ready_o   (wdata_ready),
        .wdata_i         (wdata),
        .wr_done_o       (wr_done),
        .wr_resp_o       (wr_resp),
        .ar_o            (ar_ch),
        .arvalid_o       (arvalid),
        .arready_i       (arready),
        .r_i             (r_ch),
        .rvalid_i        (rvalid),
        .rready_o        (rready),
        .aw_o            (aw_ch),
        .awvalid_o       (awvalid),
        .awready_i       (awready),
        .w_o             (w_ch),
        .wvalid_o        (wvalid),
        .wready_i        (wready),
        .bvalid_i        (bvalid),
        .bresp_i         (bresp),
        .bready_o        (bready)
    );

    bind cpu_axi_bridge bridge_props u_props (
        .aclk_i    (aclk_i),
        .arst_n_i  (arst_n_i),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .ar_o      (ar_o),
        .rready_o  (rready_o),
        .rvalid_i  (rvalid_i),
        .r_i       (r_i),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .aw_o      (aw_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .w_o       (w_o)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // power-on content, mixes every address bit
    function automatic logic [31:0] init_pattern(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (exp_wr[addr[11:2]])
            return exp_mem[addr[11:2]];
        return init_pattern(addr);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_fail(input string msg);
        fail_cnt++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic check_beat(input int port, input rd_beat_t beat);
        string pname;
        logic [32:0] exp;
        pname = (port == `BRG_ICACHE_ID) ? "ic_resp" : "dc_resp";
        if (exp_q[port].size() == 0) begin
            report_fail({pname, " delivered a beat with no read outstanding"});
        end else begin
            exp = exp_q[port].pop_front();
            check_val({pname, ".data"}, beat.data, exp[32:1]);
            check_val({pname, ".last"}, beat.last, exp[0]);
        end
    endtask

    task automatic expect_read(input int port, input logic [31:0] addr, input logic [8:0] cnt);
        for (int i = 0; i < cnt; i++)
            exp_q[port].push_back({mem_word(addr + 32'(4 * i)), i == cnt - 1});
        ar_exp[port].push_back({addr, 8'(cnt - 1)});
    endtask

    // both valids rise on the same edge when both are asked for
    task automatic issue_reads(input logic do_ic, input logic [31:0] ic_addr,
                               input logic [8:0] ic_cnt, input logic do_dc,
                               input logic [31:0] dc_addr, input logic [8:0] dc_cnt);
        logic ic_wait;
        logic dc_wait;
        ic_wait = do_ic;
        dc_wait = do_dc;
        if (do_ic)
            expect_read(`BRG_ICACHE_ID, ic_addr, ic_cnt);
        if (do_dc)
            expect_read(`BRG_DCACHE_ID, dc_addr, dc_cnt);
        @(posedge aclk);
        ic_req_valid <= do_ic;
        ic_req       <= '{ic_addr, ic_cnt};
        dc_req_valid <= do_dc;
        dc_req       <= '{dc_addr, dc_cnt};
        while (ic_wait || dc_wait) begin
            @(posedge aclk);
            if (ic_wait && ic_req_ready) begin
                ic_wait = 1'b0;
                ic_req_valid <= 1'b0;
            end
            if (dc_wait && dc_req_ready) begin
                dc_wait = 1'b0;
                dc_req_valid <= 1'b0;
            end
        end
    endtask

    task automatic wait_reads();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
            @(posedge aclk);
    endtask

    task automatic dc_write(input logic [31:0] addr, input logic [8:0] cnt);
        logic [31:0] data;
        logic [3:0] strb;
        logic [31:0] merged;
        logic [31:0] baddr;
        int start_done;
        exp_aw_addr = addr;
        exp_aw_len  = 8'(cnt - 1);
        start_done  = done_cnt;
        @(posedge aclk);
        wr_req_valid <= 1'b1;
        wr_req       <= '{addr, cnt};
        do @(posedge aclk); while (!wr_req_ready);
        wr_req_valid <= 1'b0;
        for (int i = 0; i < cnt; i++) begin
            data   = $urandom;
            strb   = 4'($urandom);
            baddr  = addr + 32'(4 * i);
            merged = mem_word(baddr);
            for (int b = 0; b < 4; b++)
                if (strb[b])
                    merged[8*b +: 8] = data[8*b +: 8];
            exp_mem[baddr[11:2]] = merged;
            exp_wr[baddr[11:2]]  = 1'b1;
            wdata_valid <= 1'b1;
            wdata       <= '{data, strb};
            do @(posedge aclk); while (!wdata_ready);
        end
        wdata_valid <= 1'b0;
        while (done_cnt == start_done)
            @(posedge aclk);
    endtask

    // AXI slave with random stalls
    always @(posedge aclk) begin
        if (!arst_n) begin
            for (int k = 0; k < 1024; k++)
                mem_q[k] <= init_pattern({20'd0, 10'(k), 2'b00});
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            r_ch    <= '0;
            bvalid  <= 1'b0;
            bresp   <= 2'b00;
            rd_addr <= '0;
            rd_left <= '0;
            rd_id   <= '0;
            wr_addr <= '0;
            b_pend  <= 1'b0;
        end else begin
            arready <= ($urandom % 4) != 0;
            awready <= ($urandom % 4) != 0;
            wready  <= ($urandom % 3) != 0;
            addr_v = rd_addr;
            left_v = rd_left;
            if (rvalid && rready) begin
                addr_v = addr_v + 32'd4;
                left_v = left_v - 9'd1;
            end
            if (!rvalid || rready) begin  // a held beat stays put
                if (left_v != 0 && ($urandom % 3) != 0) begin
                    rvalid <= 1'b1;
                    r_ch   <= '{rd_id, mem_q[addr_v[11:2]], 2'b00, left_v == 9'd1};
                end else begin
                    rvalid <= 1'b0;
                end
            end
            rd_addr <= addr_v;
            rd_left <= left_v;
            if (arvalid && arready) begin
                rd_addr <= ar_ch.addr;
                rd_left <= {1'b0, ar_ch.len} + 9'd1;
                rd_id   <= ar_ch.id;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
            else if (b_pend && !bvalid && ($urandom % 2) != 0) begin
                bvalid <= 1'b1;
                bresp  <= 2'($urandom);  // any response code
                b_pend <= 1'b0;
            end
            if (awvalid && awready)
                wr_addr <= aw_ch.addr;
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++)
                    if (w_ch.strb[b])
                        mem_q[wr_addr[11:2]][8*b +: 8] <= w_ch.data[8*b +: 8];
                wr_addr <= wr_addr + 32'd4;
                if (w_ch.last)
                    b_pend <= 1'b1;
            end
        end
    end

    // compares every beat and address against the reference
    always @(negedge aclk) begin : compare
        logic [39:0] exp_ar;
        if (arst_n) begin
            if (ic_resp_valid)
                check_beat(`BRG_ICACHE_ID, ic_resp);
            if (dc_resp_valid)
                check_beat(`BRG_DCACHE_ID, dc_resp);
            if (arvalid && arready) begin
                ar_ids.push_back(ar_ch.id);
                if (ar_ch.id > 1 || ar_exp[ar_ch.id].size() == 0) begin
                    report_fail("AR issued with an ID that has no request waiting");
                end else begin
                    exp_ar = ar_exp[ar_ch.id].pop_front();
                    check_val("ar_o.addr", ar_ch.addr, exp_ar[39:8]);
                    check_val("ar_o.len", ar_ch.len, exp_ar[7:0]);
                end
            end
            if (awvalid && awready) begin
                check_val("aw_o.id", aw_ch.id, `BRG_DCACHE_ID);
                check_val("aw_o.addr", aw_ch.addr, exp_aw_addr);
                check_val("aw_o.len", aw_ch.len, exp_aw_len);
                w_seen = 0;
            end
            if (wvalid && wready) begin
                check_val("w_o.last", w_ch.last, w_seen == exp_aw_len);
                w_seen++;
            end
            if (wr_done) begin
                check_val("bvalid at wr_done_o", bvalid, 1'b1);
                check_val("wr_resp_o", wr_resp, bresp);
                done_cnt++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout after %0d cycles, the bridge stopped making progress", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'hd89a_2d6a));
        err_cnt  = 0;
        fail_cnt = 0;
        done_cnt = 0;
        w_seen   = 0;
        for (int k = 0; k < 1024; k++)
            exp_wr[k] = 1'b0;
        arst_n       <= 1'b0;
        ic_req_valid <= 1'b0;
        ic_req       <= '0;
        dc_req_valid <= 1'b0;
        dc_req       <= '0;
        wr_req_valid <= 1'b0;
        wr_req       <= '0;
        wdata_valid  <= 1'b0;
        wdata        <= '0;
        repeat (4) @(posedge aclk);
        arst_n <= 1'b1;

        @(negedge aclk);  // idle outputs after reset
        check_val("arvalid_o", arvalid, 1'b0);
        check_val("awvalid_o", awvalid, 1'b0);
        check_val("wvalid_o", wvalid, 1'b0);
        check_val("rready_o", rready, 1'b0);
        check_val("bready_o", bready, 1'b0);
        check_val("ic_resp_valid_o", ic_resp_valid, 1'b0);
        check_val("dc_resp_valid_o", dc_resp_valid, 1'b0);
        check_val("wr_done_o", wr_done, 1'b0);
        check_val("ic_req_ready_o", ic_req_ready, 1'b1);
        check_val("dc_req_ready_o", dc_req_ready, 1'b1);
        check_val("wr_req_ready_o", wr_req_ready, 1'b1);

        issue_reads(1'b1, 32'h100, 9'd8, 1'b0, 32'h0, 9'd0);
        wait_reads();
        issue_reads(1'b0, 32'h0, 9'd0, 1'b1, 32'h200, 9'd4);
        wait_reads();

        // simultaneous pairs, grants must alternate
        order_start = ar_ids.size();
        for (int i = 0; i < 3; i++) begin
            if (i == 1) begin  // lone icache read hands priority to the dcache
                issue_reads(1'b1, 32'h3c0, 9'd4, 1'b0, 32'h0, 9'd0);
                wait_reads();
            end
            issue_reads(1'b1, 32'h300 + 32'(i * 'h40), 9'd4, 1'b1, 32'h400 + 32'(i * 'h40), 9'd4);
            wait_reads();
        end
        for (int i = order_start + 1; i < ar_ids.size(); i++)
            if (ar_ids[i] == ar_ids[i-1])
                report_fail("round robin broken, same port granted twice in a row");

        dc_write(32'h500, 9'd4);
        issue_reads(1'b1, 32'h504, 9'd2, 1'b1, 32'h500, 9'd4);
        wait_reads();

        // random mix under bus stalls
        for (int i = 0; i < 8; i++) begin
            case ($urandom % 4)
                0: issue_reads(1'b1, 32'($urandom_range(255, 0)) * 4, 9'($urandom_range(16, 1)),
                               1'b0, 32'h0, 9'd0);
                1: issue_reads(1'b0, 32'h0, 9'd0,
                               1'b1, 32'($urandom_range(255, 0)) * 4, 9'($urandom_range(16, 1)));
                2: issue_reads(1'b1, 32'($urandom_range(255, 0)) * 4, 9'($urandom_range(16, 1)),
                               1'b1, 32'($urandom_range(255, 0)) * 4, 9'($urandom_range(16, 1)));
                default: dc_write(32'($urandom_range(255, 0)) * 4, 9'($urandom_range(16, 1)));
            endcase
            wait_reads();
        end

        repeat (4) @(posedge aclk);
        $display("errors: %0d wrong values, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
